// ==== common/uart_pkg.sv ====
// Serial-side types shared by the sampler, the FIFO and the register block.
// The frame format is fixed at 8N1, so the byte width is not a parameter.

package uart_pkg;

	// One received data byte.
	typedef logic [7:0] uart_byte_t;

	// Clock cycles per serial bit, as programmed through the bus.
	typedef logic [15:0] divisor_t;

	// Index of the data bit being collected, LSB first.
	typedef logic [2:0] bit_idx_t;

	// Index of the last data bit in a frame.
	localparam bit_idx_t LAST_BIT = 3'd7;

	// Line level while no frame is on the wire.
	localparam logic LINE_IDLE = 1'b1;

	// Report for one completed frame.
	// The valid bit pulses for a single cycle, and the other fields are only
	// meaningful while it is high.
	typedef struct packed {
		logic       valid;     // One-cycle pulse per frame.
		logic       frame_err; // Stop bit was sampled low.
		uart_byte_t data;      // Received byte, bit 0 first on the wire.
	} rx_event_t;

endpackage

// ==== common/wb_pkg.sv ====
// Wishbone classic bus types and the register map of the receiver.
// Addresses are word addresses, and only four registers exist.

package wb_pkg;

	// Word address of a register.
	typedef logic [1:0] wb_addr_t;

	// Bus data word.
	typedef logic [31:0] wb_data_t;

	// Request from the bus master.
	typedef struct packed {
		logic     cyc; // Bus cycle in progress.
		logic     stb; // Valid transfer.
		logic     we;  // High for a write.
		wb_addr_t adr;
		wb_data_t dat; // Write data.
	} wb_req_t;

	// Response from the slave.
	typedef struct packed {
		logic     ack; // One cycle per transfer.
		wb_data_t dat; // Read data, valid with ack.
	} wb_rsp_t;

	// Register addresses.
	localparam wb_addr_t ADDR_DATA    = 2'd0; // Head of the receive FIFO, popped on read.
	localparam wb_addr_t ADDR_STATUS  = 2'd1; // Cleared on read, except the not-empty bit.
	localparam wb_addr_t ADDR_DIVISOR = 2'd2;
	localparam wb_addr_t ADDR_CTRL    = 2'd3;

	// Bit positions in the STATUS register.
	localparam int STAT_NOT_EMPTY = 0;
	localparam int STAT_OVERRUN   = 1; // A byte arrived while the FIFO was full.
	localparam int STAT_FRAME_ERR = 2; // A frame ended with a low stop bit.

	// Bit positions in the CTRL register.
	localparam int CTRL_ENABLE = 0;

endpackage

// ==== uart_rx/uart_rx.sv ====
// Samples each bit once at its middle, with no oversampling or voting.
// divisor_i should be at least 4 and must not change while a frame is received.
`timescale 1ns/1ps

module uart_rx (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 rx_i,
	input  logic                 enable_i,
	input  uart_pkg::divisor_t   divisor_i,
	output uart_pkg::rx_event_t  rx_event_o
);
	import uart_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_DATA,
		S_STOP,
		S_WAIT_HIGH
	} state_t;

	state_t     state_q;
	state_t     state_d;
	logic       rx_meta_q;
	logic       rx_sync_q;
	divisor_t   timer_q;
	divisor_t   half_last;
	divisor_t   full_last;
	logic       start_tick;
	logic       bit_tick;
	logic       timer_restart;
	bit_idx_t   bit_cnt_q;
	uart_byte_t shift_q;
	logic       evt_valid_q;
	logic       evt_frame_err_q;
	uart_byte_t evt_data_q;

	// The line is asynchronous to clk.
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			rx_meta_q <= LINE_IDLE;
			rx_sync_q <= LINE_IDLE;
		end
		else
		begin
			rx_meta_q <= rx_i;
			rx_sync_q <= rx_meta_q;
		end
	end

	// The timer counts from zero, so a tick on count N-1 samples N cycles
	// after the restart.
	assign half_last = (divisor_i >> 1) - 1'b1;
	assign full_last = divisor_i - 1'b1;

	assign start_tick = (state_q == S_START) && (timer_q == half_last);
	assign bit_tick   = ((state_q == S_DATA) || (state_q == S_STOP)) && (timer_q == full_last);

	assign timer_restart = (state_q == S_IDLE) || (state_q == S_WAIT_HIGH) ||
		start_tick || bit_tick;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			S_IDLE:
			begin
				if (enable_i && !rx_sync_q)
					state_d = S_START;
			end
			S_START:
			begin
				// A line that is high again at mid-bit was a glitch.
				if (start_tick)
					state_d = rx_sync_q ? S_IDLE : S_DATA;
			end
			S_DATA:
			begin
				if (bit_tick && (bit_cnt_q == LAST_BIT))
					state_d = S_STOP;
			end
			S_STOP:
			begin
				if (bit_tick)
					state_d = S_WAIT_HIGH;
			end
			S_WAIT_HIGH:
			begin
				// A low stop bit may be a break, so hold off until the line recovers.
				if (rx_sync_q == LINE_IDLE)
					state_d = S_IDLE;
			end
			default:
			begin
				state_d = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			state_q     <= S_IDLE;
			timer_q     <= '0;
			bit_cnt_q   <= '0;
			evt_valid_q <= 1'b0;
		end
		else
		begin
			state_q     <= state_d;
			timer_q     <= timer_restart ? '0 : timer_q + 1'b1;
			evt_valid_q <= bit_tick && (state_q == S_STOP); // Pulses once per frame.
			if (state_q == S_IDLE)
				bit_cnt_q <= '0;
			else if (bit_tick && (state_q == S_DATA))
				bit_cnt_q <= bit_cnt_q + 1'b1;
		end
	end

	// Data bits arrive LSB first, so they enter at the top and move down.
	always_ff @(posedge clk)
	begin
		if (bit_tick && (state_q == S_DATA))
			shift_q <= {rx_sync_q, shift_q[7:1]};
		if (bit_tick && (state_q == S_STOP))
		begin
			evt_data_q      <= shift_q;
			evt_frame_err_q <= !rx_sync_q;
		end
	end

	assign rx_event_o.valid     = evt_valid_q;
	assign rx_event_o.frame_err = evt_frame_err_q;
	assign rx_event_o.data      = evt_data_q;

endmodule

// ==== logic/rx_fifo.sv ====
// FIFO_DEPTH must be a power of two and at least 2.
// Frames with a framing error are never stored, and a full FIFO drops new bytes.
`timescale 1ns/1ps

module rx_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                 clk,
	input  logic                 resetn,
	input  uart_pkg::rx_event_t  rx_event_i,
	input  logic                 pop_i,
	output uart_pkg::uart_byte_t head_o,
	output logic                 empty_o,
	output logic                 drop_o
);
	import uart_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	// The extra top bit tells a full FIFO from an empty one.
	typedef logic [AW:0] ptr_t;

	uart_byte_t mem [FIFO_DEPTH];
	ptr_t       wr_ptr_q;
	ptr_t       rd_ptr_q;
	logic       full;
	logic       push;
	logic       do_push;
	logic       do_pop;
	logic       drop_q;

	assign empty_o = (wr_ptr_q == rd_ptr_q);
	assign full    = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
		(wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

	assign push   = rx_event_i.valid && !rx_event_i.frame_err;
	assign do_pop = pop_i && !empty_o;

	// A pop in the same cycle frees the slot that the new byte goes into.
	assign do_push = push && (!full || do_pop);

	assign head_o = mem[rd_ptr_q[AW-1:0]];
	assign drop_o = drop_q;

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr_q[AW-1:0]] <= rx_event_i.data;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			drop_q   <= 1'b0;
		end
		else
		begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			drop_q <= push && !do_push; // The byte is lost, so tell the register block.
		end
	end

endmodule

// ==== logic/wb_uart_regs.sv ====
// Every access is acked one cycle after it is seen, with no wait states.
// A DATA read of an empty FIFO returns 0 and pops nothing.
`timescale 1ns/1ps

module wb_uart_regs #(
	parameter uart_pkg::divisor_t RESET_DIVISOR = 16
) (
	input  logic                 clk,
	input  logic                 resetn,
	input  wb_pkg::wb_req_t      wb_req_i,
	output wb_pkg::wb_rsp_t      wb_rsp_o,
	input  uart_pkg::uart_byte_t head_i,
	input  logic                 empty_i,
	input  logic                 drop_i,
	input  logic                 frame_err_i,
	output logic                 pop_o,
	output uart_pkg::divisor_t   divisor_o,
	output logic                 enable_o
);
	import wb_pkg::*;
	import uart_pkg::*;

	logic     ack_q;
	wb_data_t rdata_q;
	wb_data_t rdata_d;
	divisor_t divisor_q;
	logic     enable_q;
	logic     overrun_q;
	logic     frame_err_q;
	logic     pop_q;
	logic     access;
	logic     rd_access;
	logic     wr_access;
	logic     status_rd;

	// The ack itself blocks a second access while the master still holds stb.
	assign access    = wb_req_i.cyc && wb_req_i.stb && !ack_q;
	assign rd_access = access && !wb_req_i.we;
	assign wr_access = access && wb_req_i.we;
	assign status_rd = rd_access && (wb_req_i.adr == ADDR_STATUS);

	always_comb
	begin
		rdata_d = '0;
		case (wb_req_i.adr)
			ADDR_DATA:
			begin
				if (!empty_i)
					rdata_d[$bits(uart_byte_t)-1:0] = head_i;
			end
			ADDR_STATUS:
			begin
				rdata_d[STAT_NOT_EMPTY] = !empty_i;
				rdata_d[STAT_OVERRUN]   = overrun_q;
				rdata_d[STAT_FRAME_ERR] = frame_err_q;
			end
			ADDR_DIVISOR:
			begin
				rdata_d[$bits(divisor_t)-1:0] = divisor_q;
			end
			ADDR_CTRL:
			begin
				rdata_d[CTRL_ENABLE] = enable_q;
			end
			default:
			begin
				rdata_d = '0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			ack_q       <= 1'b0;
			pop_q       <= 1'b0;
			divisor_q   <= RESET_DIVISOR;
			enable_q    <= 1'b0;
			overrun_q   <= 1'b0;
			frame_err_q <= 1'b0;
		end
		else
		begin
			ack_q <= access;
			// The head byte is already captured, so the pop lines up with the ack.
			pop_q <= rd_access && (wb_req_i.adr == ADDR_DATA) && !empty_i;

			// A new event wins over the clear of the same cycle.
			overrun_q   <= drop_i || (overrun_q && !status_rd);
			frame_err_q <= frame_err_i || (frame_err_q && !status_rd);

			if (wr_access && (wb_req_i.adr == ADDR_DIVISOR))
				divisor_q <= wb_req_i.dat[$bits(divisor_t)-1:0];
			if (wr_access && (wb_req_i.adr == ADDR_CTRL))
				enable_q <= wb_req_i.dat[CTRL_ENABLE];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_access)
			rdata_q <= rdata_d;
	end

	assign wb_rsp_o.ack = ack_q;
	assign wb_rsp_o.dat = rdata_q;

	assign pop_o     = pop_q;
	assign divisor_o = divisor_q;
	assign enable_o  = enable_q;

endmodule

// ==== logic/uart_rx_top.sv ====
// UART receiver with a Wishbone classic register port, fixed 8N1 framing.
// FIFO_DEPTH must be a power of two, and reception is off until CTRL is written.
`timescale 1ns/1ps

module uart_rx_top #(
	parameter int                 FIFO_DEPTH    = 8,
	parameter uart_pkg::divisor_t RESET_DIVISOR = 16
) (
	input  logic            clk,
	input  logic            resetn,
	input  logic            rx_i,
	input  wb_pkg::wb_req_t wb_req_i,
	output wb_pkg::wb_rsp_t wb_rsp_o
);
	import uart_pkg::*;

	rx_event_t  rx_event;
	uart_byte_t head;
	logic       empty;
	logic       drop;
	logic       pop;
	logic       frame_err;
	divisor_t   divisor;
	logic       enable;

	// Only a completed frame can raise the framing flag.
	assign frame_err = rx_event.valid && rx_event.frame_err;

	uart_rx u_uart_rx (
		.clk        (clk),
		.resetn     (resetn),
		.rx_i       (rx_i),
		.enable_i   (enable),
		.divisor_i  (divisor),
		.rx_event_o (rx_event)
	);

	rx_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_rx_fifo (
		.clk        (clk),
		.resetn     (resetn),
		.rx_event_i (rx_event),
		.pop_i      (pop),
		.head_o     (head),
		.empty_o    (empty),
		.drop_o     (drop)
	);

	wb_uart_regs #(
		.RESET_DIVISOR (RESET_DIVISOR)
	) u_wb_uart_regs (
		.clk         (clk),
		.resetn      (resetn),
		.wb_req_i    (wb_req_i),
		.wb_rsp_o    (wb_rsp_o),
		.head_i      (head),
		.empty_i     (empty),
		.drop_i      (drop),
		.frame_err_i (frame_err),
		.pop_o       (pop),
		.divisor_o   (divisor),
		.enable_o    (enable)
	);

endmodule

// ==== bench/tb_uart_rx_top.sv ====
// Directed testbench for the UART receiver with its Wishbone register port.
// Stops at the first error, and every wait on the DUT is bounded by a cycle limit.
`timescale 1ns/1ps

module tb_uart_rx_top;
	import uart_pkg::*;
	import wb_pkg::*;

	localparam int ACK_LIMIT  = 8;   // Cycles allowed for one bus access.
	localparam int POLL_LIMIT = 64;  // STATUS reads allowed while waiting for an event.

	logic        clk;
	logic        resetn;
	logic        rx;
	wb_req_t     wb_req;
	wb_rsp_t     wb_rsp;
	int          bit_period;
	logic [31:0] lfsr;

	uart_rx_top #(
		.FIFO_DEPTH    (8),
		.RESET_DIVISOR (16)
	) uut (
		.clk      (clk),
		.resetn   (resetn),
		.rx_i     (rx),
		.wb_req_i (wb_req),
		.wb_rsp_o (wb_rsp)
	);

	always #2 clk = ~clk;

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic check_value(input string name, input wb_data_t expected, input wb_data_t actual);
		if (expected !== actual)
			stop_run($sformatf("FAIL %s expected 0x%h got 0x%h", name, expected, actual));
	endtask

	// Fibonacci LFSR with taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_byte(output uart_byte_t b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_next(lfsr);
			b[i] = lfsr[0]; // One step per bit taken.
		end
	endtask

	// All bus and line tasks start and end 1 ns after a rising edge.
	task automatic wb_access(input logic we, input wb_addr_t addr, input wb_data_t wdata,
		output wb_data_t rdata);
		int cycles;
		cycles = 0;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = addr;
		wb_req.dat = wdata;
		@(posedge clk);
		#1;
		while (!wb_rsp.ack)
		begin
			if (cycles == ACK_LIMIT)
				stop_run($sformatf("No ack from the DUT for the access to address %0d.", addr));
			cycles++;
			@(posedge clk);
			#1;
		end
		rdata  = wb_rsp.dat; // Registered read data is stable while ack is high.
		wb_req = '0;
	endtask

	task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
		wb_access(1'b0, addr, '0, data);
	endtask

	task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
		wb_data_t unused;
		wb_access(1'b1, addr, data, unused);
	endtask

	task automatic hold_line(input logic level, input int cycles);
		rx = level;
		repeat (cycles) @(posedge clk);
		#1;
	endtask

	// One 8N1 frame followed by one bit period of idle line.
	task automatic send_byte(input uart_byte_t data, input logic stop_bit);
		hold_line(1'b0, bit_period);
		for (int i = 0; i < 8; i++)
			hold_line(data[i], bit_period);
		hold_line(stop_bit, bit_period);
		hold_line(1'b1, bit_period);
	endtask

	// Polls STATUS until a bit in mask is set and returns that read.
	task automatic wait_status(input wb_data_t mask, output wb_data_t value);
		int polls;
		polls = 0;
		wb_read(ADDR_STATUS, value);
		while ((value & mask) == '0)
		begin
			if (polls == POLL_LIMIT)
				stop_run("The expected STATUS flag never came up.");
			polls++;
			wb_read(ADDR_STATUS, value);
		end
	endtask

	task automatic test_reset_values;
		wb_data_t   rdata;
		uart_byte_t b;
		wb_read(ADDR_STATUS, rdata);
		check_value("status", 32'h0, rdata);
		wb_read(ADDR_DIVISOR, rdata);
		check_value("divisor", 32'd16, rdata);
		wb_read(ADDR_CTRL, rdata);
		check_value("ctrl", 32'h0, rdata);
		rand_byte(b);
		send_byte(b, 1'b1); // Reception is still disabled.
		wb_read(ADDR_STATUS, rdata);
		check_value("status", 32'h0, rdata);
	endtask

	task automatic test_config;
		wb_data_t rdata;
		wb_write(ADDR_DIVISOR, 32'd10);
		wb_read(ADDR_DIVISOR, rdata);
		check_value("divisor", 32'd10, rdata);
		wb_write(ADDR_CTRL, 32'd1);
		wb_read(ADDR_CTRL, rdata);
		check_value("ctrl", 32'd1, rdata);
		bit_period = 10;
	endtask

	task automatic test_receive_bytes;
		wb_data_t   rdata;
		uart_byte_t b;
		for (int n = 0; n < 5; n++)
		begin
			rand_byte(b);
			send_byte(b, 1'b1);
			wait_status(32'h1 << STAT_NOT_EMPTY, rdata);
			check_value("status", 32'h1 << STAT_NOT_EMPTY, rdata);
			wb_read(ADDR_DATA, rdata);
			check_value("data", {24'h0, b}, rdata);
		end
		wb_read(ADDR_STATUS, rdata);
		check_value("status", 32'h0, rdata);
		wb_read(ADDR_DATA, rdata);
		check_value("data", 32'h0, rdata); // Empty FIFO reads as zero.
	endtask

	task automatic test_overrun;
		wb_data_t   rdata;
		uart_byte_t sent [10];
		for (int n = 0; n < 10; n++)
		begin
			rand_byte(sent[n]);
			send_byte(sent[n], 1'b1);
		end
		wait_status(32'h1 << STAT_OVERRUN, rdata);
		check_value("status", (32'h1 << STAT_OVERRUN) | (32'h1 << STAT_NOT_EMPTY), rdata);
		for (int n = 0; n < 8; n++)
		begin
			wb_read(ADDR_DATA, rdata);
			check_value("data", {24'h0, sent[n]}, rdata); // The last two bytes were dropped.
		end
		wb_read(ADDR_STATUS, rdata);
		check_value("status", 32'h0, rdata);
	endtask

	task automatic test_framing_error;
		wb_data_t   rdata;
		uart_byte_t b;
		rand_byte(b);
		send_byte(b, 1'b0);
		wait_status(32'h1 << STAT_FRAME_ERR, rdata);
		check_value("status", 32'h1 << STAT_FRAME_ERR, rdata);
		wb_read(ADDR_STATUS, rdata);
		check_value("status", 32'h0, rdata);
	endtask

	task automatic test_glitch;
		wb_data_t   rdata;
		uart_byte_t b;
		hold_line(1'b0, bit_period / 2 - 2); // Too short to pass the mid-bit check.
		hold_line(1'b1, 12 * bit_period); // A false start would finish a whole frame by now.
		wb_read(ADDR_STATUS, rdata);
		check_value("status", 32'h0, rdata);
		rand_byte(b);
		send_byte(b, 1'b1);
		wait_status(32'h1 << STAT_NOT_EMPTY, rdata);
		check_value("status", 32'h1 << STAT_NOT_EMPTY, rdata);
		wb_read(ADDR_DATA, rdata);
		check_value("data", {24'h0, b}, rdata);
	endtask

	initial
	begin
		clk        = 1'b0;
		resetn     = 1'b0;
		rx         = 1'b1;
		wb_req     = '0;
		bit_period = 16;
		lfsr       = 32'hd3972109;
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;
		test_reset_values();
		test_config();
		test_receive_bytes();
		test_overrun();
		test_framing_error();
		test_glitch();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// ==== sources.f ====
common/uart_pkg.sv
common/wb_pkg.sv
uart_rx/uart_rx.sv
logic/rx_fifo.sv
logic/wb_uart_regs.sv
logic/uart_rx_top.sv
bench/tb_uart_rx_top.sv
